//--- source/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath and register file
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// instruction fields
`define OPCODE_W    4
`define IMM_W       12
`define OP_LSB      28
`define RD_LSB      23
`define RS1_LSB     18
// rs2 shares its bits with the upper immediate
`define RS2_LSB     7
`define IMM_LSB     0

// instruction buffer
`define IB_DEPTH    8
`define IB_CNT_W    4

// lanes, also max push or pop per cycle
`define ISSUE_W     2

`endif

//--- source/core_pkg.sv
`include "core_consts.svh"

package core_pkg;

  // toy ISA opcodes, top field of the instruction word
  typedef enum logic [`OPCODE_W-1:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_OR   = 4'd3,
    OP_XOR  = 4'd4,
    OP_SLT  = 4'd5,
    OP_ADDI = 4'd6,
    OP_LUI  = 4'd7
  } op_e;

  // decoded micro-op handed from issue to a lane
  // b already holds rs2 or the extended immediate
  typedef struct packed {
    op_e                    op;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       a;
    logic [`XLEN-1:0]       b;
  } uop_t;

endpackage

//--- source/instr_buffer.sv
`timescale 1ns/100ps
`include "core_consts.svh"

module instr_buffer #(
  parameter int DEPTH = `IB_DEPTH
) (
  input  logic                 aclk,
  input  logic                 arst_n,
  input  logic [1:0]           push_num,
  input  logic [`XLEN-1:0]     push_instr0,
  input  logic [`XLEN-1:0]     push_instr1,
  input  logic [1:0]           pop_num,
  output logic [`XLEN-1:0]     head_instr0,
  output logic [`XLEN-1:0]     head_instr1,
  output logic                 head_valid0,
  output logic                 head_valid1,
  output logic [`IB_CNT_W-1:0] free_slots
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = `IB_CNT_W;

  logic [`XLEN-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr_nxt;
  logic [PTR_W-1:0] rd_ptr_nxt;
  logic [CNT_W-1:0] count;

  // second slot of each pair, wraps with the pointer width
  assign wr_ptr_nxt = wr_ptr + PTR_W'(1);
  assign rd_ptr_nxt = rd_ptr + PTR_W'(1);

  // oldest two entries
  assign head_instr0 = mem[rd_ptr];
  assign head_instr1 = mem[rd_ptr_nxt];
  assign head_valid0 = (count != '0);
  assign head_valid1 = (count > CNT_W'(1));

  assign free_slots = CNT_W'(DEPTH) - count;

  // pointers and occupancy
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + PTR_W'(push_num);
      rd_ptr <= rd_ptr + PTR_W'(pop_num);
      count  <= count + CNT_W'(push_num) - CNT_W'(pop_num);
    end
  end

  // storage, instr0 is the older of a pushed pair
  always_ff @(posedge aclk) begin
    if (push_num != 2'd0) begin
      mem[wr_ptr] <= push_instr0;
    end
    if (push_num == 2'd2) begin
      mem[wr_ptr_nxt] <= push_instr1;
    end
  end

endmodule

//--- source/issue_stage.sv
`timescale 1ns/100ps
`include "core_consts.svh"

module issue_stage (
  input  logic                   aclk,
  input  logic                   arst_n,
  input  logic [`XLEN-1:0]       head_instr0,
  input  logic [`XLEN-1:0]       head_instr1,
  input  logic                   head_valid0,
  input  logic                   head_valid1,
  output logic [1:0]             pop_num,
  output logic [`REG_ADDR_W-1:0] rf_raddr0,
  output logic [`REG_ADDR_W-1:0] rf_raddr1,
  output logic [`REG_ADDR_W-1:0] rf_raddr2,
  output logic [`REG_ADDR_W-1:0] rf_raddr3,
  input  logic [`XLEN-1:0]       rf_rdata0,
  input  logic [`XLEN-1:0]       rf_rdata1,
  input  logic [`XLEN-1:0]       rf_rdata2,
  input  logic [`XLEN-1:0]       rf_rdata3,
  input  logic                   fwd_valid0,
  input  logic                   fwd_valid1,
  input  logic [`REG_ADDR_W-1:0] fwd_rd0,
  input  logic [`REG_ADDR_W-1:0] fwd_rd1,
  input  logic [`XLEN-1:0]       fwd_data0,
  input  logic [`XLEN-1:0]       fwd_data1,
  output core_pkg::uop_t         uop0,
  output core_pkg::uop_t         uop1,
  output logic                   uop_valid0,
  output logic                   uop_valid1
);

  logic [`REG_ADDR_W-1:0] rd0;
  logic [`REG_ADDR_W-1:0] rs1_1;
  logic [`REG_ADDR_W-1:0] rs2_1;
  core_pkg::op_e          op1;
  logic                   dep1;
  logic                   issue1;
  core_pkg::uop_t         uop0_d;
  core_pkg::uop_t         uop1_d;

  // younger lane wins when both lanes hit the same register
  function automatic logic [`XLEN-1:0] fwd_sel(input logic [`REG_ADDR_W-1:0] rs,
                                                input logic [`XLEN-1:0]       rf_val);
    logic [`XLEN-1:0] val;
    val = rf_val;
    if (rs != '0) begin
      if (fwd_valid1 && fwd_rd1 == rs) begin
        val = fwd_data1;
      end else if (fwd_valid0 && fwd_rd0 == rs) begin
        val = fwd_data0;
      end
    end
    return val;
  endfunction

  function automatic core_pkg::uop_t make_uop(input logic [`XLEN-1:0] instr,
                                              input logic [`XLEN-1:0] a_val,
                                              input logic [`XLEN-1:0] b_val);
    logic [`IMM_W-1:0] imm;
    core_pkg::uop_t    u;
    imm  = instr[`IMM_LSB +: `IMM_W];
    u.op = core_pkg::op_e'(instr[`OP_LSB +: `OPCODE_W]);
    u.rd = instr[`RD_LSB +: `REG_ADDR_W];
    u.a  = a_val;
    u.b  = b_val;
    case (u.op)
      core_pkg::OP_ADDI: u.b = {{(`XLEN-`IMM_W){imm[`IMM_W-1]}}, imm};
      core_pkg::OP_LUI: begin
        u.a = '0;
        u.b = {imm, {(`XLEN-`IMM_W){1'b0}}};
      end
      default: ;
    endcase
    return u;
  endfunction

  assign rd0   = head_instr0[`RD_LSB +: `REG_ADDR_W];
  assign rs1_1 = head_instr1[`RS1_LSB +: `REG_ADDR_W];
  assign rs2_1 = head_instr1[`RS2_LSB +: `REG_ADDR_W];
  assign op1   = core_pkg::op_e'(head_instr1[`OP_LSB +: `OPCODE_W]);

  assign rf_raddr0 = head_instr0[`RS1_LSB +: `REG_ADDR_W];
  assign rf_raddr1 = head_instr0[`RS2_LSB +: `REG_ADDR_W];
  assign rf_raddr2 = rs1_1;
  assign rf_raddr3 = rs2_1;

  // does the second head read what the first one writes
  always_comb begin
    dep1 = 1'b0;
    if (rd0 != '0) begin
      if (op1 != core_pkg::OP_LUI && rs1_1 == rd0) begin
        dep1 = 1'b1;
      end
      if (!(op1 inside {core_pkg::OP_ADDI, core_pkg::OP_LUI}) && rs2_1 == rd0) begin
        dep1 = 1'b1;
      end
    end
  end

  assign issue1  = head_valid0 && head_valid1 && !dep1;
  assign pop_num = issue1 ? 2'd2 : {1'b0, head_valid0};

  always_comb begin
    uop0_d = make_uop(head_instr0, fwd_sel(rf_raddr0, rf_rdata0), fwd_sel(rf_raddr1, rf_rdata1));
    uop1_d = make_uop(head_instr1, fwd_sel(rf_raddr2, rf_rdata2), fwd_sel(rf_raddr3, rf_rdata3));
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      uop_valid0 <= 1'b0;
      uop_valid1 <= 1'b0;
    end else begin
      uop_valid0 <= head_valid0;
      uop_valid1 <= issue1;
    end
  end

  always_ff @(posedge aclk) begin
    uop0 <= uop0_d;
    uop1 <= uop1_d;
  end

endmodule

//--- source/reg_file.sv
`timescale 1ns/100ps
`include "core_consts.svh"

module reg_file (
  input  logic                   aclk,
  input  logic                   arst_n,
  input  logic [`REG_ADDR_W-1:0] raddr0,
  input  logic [`REG_ADDR_W-1:0] raddr1,
  input  logic [`REG_ADDR_W-1:0] raddr2,
  input  logic [`REG_ADDR_W-1:0] raddr3,
  output logic [`XLEN-1:0]       rdata0,
  output logic [`XLEN-1:0]       rdata1,
  output logic [`XLEN-1:0]       rdata2,
  output logic [`XLEN-1:0]       rdata3,
  input  logic                   we0,
  input  logic                   we1,
  input  logic [`REG_ADDR_W-1:0] waddr0,
  input  logic [`REG_ADDR_W-1:0] waddr1,
  input  logic [`XLEN-1:0]       wdata0,
  input  logic [`XLEN-1:0]       wdata1
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // write-through, port 1 is the younger write
  function automatic logic [`XLEN-1:0] rd_port(input logic [`REG_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] val;
    val = regs[addr];
    if (addr == '0) begin
      val = '0;
    end else if (we1 && waddr1 == addr) begin
      val = wdata1;
    end else if (we0 && waddr0 == addr) begin
      val = wdata0;
    end
    return val;
  endfunction

  always_comb begin
    rdata0 = rd_port(raddr0);
    rdata1 = rd_port(raddr1);
    rdata2 = rd_port(raddr2);
    rdata3 = rd_port(raddr3);
  end

  // r0 never written, later write wins on a clash
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (we0 && waddr0 != '0) begin
        regs[waddr0] <= wdata0;
      end
      if (we1 && waddr1 != '0) begin
        regs[waddr1] <= wdata1;
      end
    end
  end

endmodule

//--- source/exec_lane.sv
`timescale 1ns/100ps
`include "core_consts.svh"

module exec_lane (
  input  logic                   aclk,
  input  logic                   arst_n,
  input  core_pkg::uop_t         uop,
  input  logic                   uop_valid,
  output logic                   fwd_valid,
  output logic [`REG_ADDR_W-1:0] fwd_rd,
  output logic [`XLEN-1:0]       fwd_data,
  output logic                   commit_valid,
  output logic [`REG_ADDR_W-1:0] commit_rd,
  output logic [`XLEN-1:0]       commit_data
);

  logic [`XLEN-1:0] result;
  logic             lt;

  assign lt = ($signed(uop.a) < $signed(uop.b));

  // operand b is already rs2 or the immediate
  always_comb begin
    case (uop.op)
      core_pkg::OP_ADD:  result = uop.a + uop.b;
      core_pkg::OP_SUB:  result = uop.a - uop.b;
      core_pkg::OP_AND:  result = uop.a & uop.b;
      core_pkg::OP_OR:   result = uop.a | uop.b;
      core_pkg::OP_XOR:  result = uop.a ^ uop.b;
      core_pkg::OP_SLT:  result = {{(`XLEN-1){1'b0}}, lt};
      core_pkg::OP_ADDI: result = uop.a + uop.b;
      core_pkg::OP_LUI:  result = uop.b;
      default:           result = '0;
    endcase
  end

  // result while executing, seen by issue
  assign fwd_valid = uop_valid;
  assign fwd_rd    = uop.rd;
  assign fwd_data  = result;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= uop_valid;
    end
  end

  always_ff @(posedge aclk) begin
    commit_rd   <= uop.rd;
    commit_data <= result;
  end

endmodule

//--- source/core_top.sv
`timescale 1ns/100ps
`include "core_consts.svh"

module core_top (
  input  logic                   aclk,
  input  logic                   arst_n,
  input  logic [1:0]             push_num,
  input  logic [`XLEN-1:0]       push_instr0,
  input  logic [`XLEN-1:0]       push_instr1,
  output logic [`IB_CNT_W-1:0]   free_slots,
  output logic                   commit_valid0,
  output logic                   commit_valid1,
  output logic [`REG_ADDR_W-1:0] commit_rd0,
  output logic [`REG_ADDR_W-1:0] commit_rd1,
  output logic [`XLEN-1:0]       commit_data0,
  output logic [`XLEN-1:0]       commit_data1
);

  logic [`XLEN-1:0]       head_instr0;
  logic [`XLEN-1:0]       head_instr1;
  logic                   head_valid0;
  logic                   head_valid1;
  logic [1:0]             pop_num;
  logic [`REG_ADDR_W-1:0] rf_raddr0;
  logic [`REG_ADDR_W-1:0] rf_raddr1;
  logic [`REG_ADDR_W-1:0] rf_raddr2;
  logic [`REG_ADDR_W-1:0] rf_raddr3;
  logic [`XLEN-1:0]       rf_rdata0;
  logic [`XLEN-1:0]       rf_rdata1;
  logic [`XLEN-1:0]       rf_rdata2;
  logic [`XLEN-1:0]       rf_rdata3;
  logic                   fwd_valid0;
  logic                   fwd_valid1;
  logic [`REG_ADDR_W-1:0] fwd_rd0;
  logic [`REG_ADDR_W-1:0] fwd_rd1;
  logic [`XLEN-1:0]       fwd_data0;
  logic [`XLEN-1:0]       fwd_data1;
  core_pkg::uop_t         uop0;
  core_pkg::uop_t         uop1;
  logic                   uop_valid0;
  logic                   uop_valid1;

  instr_buffer u_ibuf (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .push_num    (push_num),
    .push_instr0 (push_instr0),
    .push_instr1 (push_instr1),
    .pop_num     (pop_num),
    .head_instr0 (head_instr0),
    .head_instr1 (head_instr1),
    .head_valid0 (head_valid0),
    .head_valid1 (head_valid1),
    .free_slots  (free_slots)
  );

  issue_stage u_issue (
    .aclk        (aclk),
    .arst_n      (arst_n),
    .head_instr0 (head_instr0),
    .head_instr1 (head_instr1),
    .head_valid0 (head_valid0),
    .head_valid1 (head_valid1),
    .pop_num     (pop_num),
    .rf_raddr0   (rf_raddr0),
    .rf_raddr1   (rf_raddr1),
    .rf_raddr2   (rf_raddr2),
    .rf_raddr3   (rf_raddr3),
    .rf_rdata0   (rf_rdata0),
    .rf_rdata1   (rf_rdata1),
    .rf_rdata2   (rf_rdata2),
    .rf_rdata3   (rf_rdata3),
    .fwd_valid0  (fwd_valid0),
    .fwd_valid1  (fwd_valid1),
    .fwd_rd0     (fwd_rd0),
    .fwd_rd1     (fwd_rd1),
    .fwd_data0   (fwd_data0),
    .fwd_data1   (fwd_data1),
    .uop0        (uop0),
    .uop1        (uop1),
    .uop_valid0  (uop_valid0),
    .uop_valid1  (uop_valid1)
  );

  // write ports fed straight from the lane commits
  reg_file u_rf (
    .aclk   (aclk),
    .arst_n (arst_n),
    .raddr0 (rf_raddr0),
    .raddr1 (rf_raddr1),
    .raddr2 (rf_raddr2),
    .raddr3 (rf_raddr3),
    .rdata0 (rf_rdata0),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2),
    .rdata3 (rf_rdata3),
    .we0    (commit_valid0),
    .we1    (commit_valid1),
    .waddr0 (commit_rd0),
    .waddr1 (commit_rd1),
    .wdata0 (commit_data0),
    .wdata1 (commit_data1)
  );

  exec_lane u_lane0 (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .uop          (uop0),
    .uop_valid    (uop_valid0),
    .fwd_valid    (fwd_valid0),
    .fwd_rd       (fwd_rd0),
    .fwd_data     (fwd_data0),
    .commit_valid (commit_valid0),
    .commit_rd    (commit_rd0),
    .commit_data  (commit_data0)
  );

  exec_lane u_lane1 (
    .aclk         (aclk),
    .arst_n       (arst_n),
    .uop          (uop1),
    .uop_valid    (uop_valid1),
    .fwd_valid    (fwd_valid1),
    .fwd_rd       (fwd_rd1),
    .fwd_data     (fwd_data1),
    .commit_valid (commit_valid1),
    .commit_rd    (commit_rd1),
    .commit_data  (commit_data1)
  );

endmodule

//--- test/core_top_checker.sv
`timescale 1ns/100ps
`include "core_consts.svh"

module core_top_checker (
  input logic                 aclk,
  input logic                 arst_n,
  input logic [1:0]           push_num,
  input logic [`IB_CNT_W-1:0] free_slots,
  input logic                 commit_valid0,
  input logic                 commit_valid1
);

  localparam int CNT_W = `IB_CNT_W;
  localparam logic [CNT_W-1:0] MAX_FREE = CNT_W'(`IB_DEPTH);

  // lane1 holds the younger commit, never alone
  a_commit_pair: assert property (@(posedge aclk) disable iff (!arst_n)
    commit_valid1 |-> commit_valid0)
    else $error("lane1 committed without lane0");

  a_free_range: assert property (@(posedge aclk) disable iff (!arst_n)
    free_slots <= MAX_FREE)
    else $error("free_slots above buffer depth");

  // producer side rule on the push port
  a_push_bound: assert property (@(posedge aclk) disable iff (!arst_n)
    CNT_W'(push_num) <= free_slots)
    else $error("push_num larger than free_slots");

  a_reset_quiet: assert property (@(posedge aclk)
    $rose(arst_n) |-> !commit_valid0 && !commit_valid1)
    else $error("commit valid right after reset");

endmodule

bind core_top core_top_checker u_checker (
  .aclk          (aclk),
  .arst_n        (arst_n),
  .push_num      (push_num),
  .free_slots    (free_slots),
  .commit_valid0 (commit_valid0),
  .commit_valid1 (commit_valid1)
);

//--- test/core_top_tb.sv
`timescale 1ns/100ps
`include "core_consts.svh"

module core_top_tb;

  localparam int CNT_W       = `IB_CNT_W;
  localparam int N_OPS       = 40;
  localparam int N_PAIRS     = 8;
  localparam int N_CHAIN     = 23;
  localparam int N_FILL      = 40;
  localparam int N_RAND      = 300;
  localparam int WDOG_CYCLES = (N_OPS + N_PAIRS + N_CHAIN + N_FILL + N_RAND) * 8 + 100;

  logic                   aclk;
  logic                   arst_n;
  logic [1:0]             push_num;
  logic [`XLEN-1:0]       push_instr0;
  logic [`XLEN-1:0]       push_instr1;
  logic [`IB_CNT_W-1:0]   free_slots;
  logic                   commit_valid0;
  logic                   commit_valid1;
  logic [`REG_ADDR_W-1:0] commit_rd0;
  logic [`REG_ADDR_W-1:0] commit_rd1;
  logic [`XLEN-1:0]       commit_data0;
  logic [`XLEN-1:0]       commit_data1;

  logic [`XLEN-1:0]       model_regs [`NUM_REGS];
  logic [`XLEN-1:0]       prog_q [$];
  logic [`REG_ADDR_W-1:0] exp_rd_q [$];
  logic [`XLEN-1:0]       exp_data_q [$];
  logic [`IB_CNT_W-1:0]   min_free;
  string                  cur_test;
  int                     err_cnt;
  int                     check_cnt;
  int                     test_cnt;
  int                     test_err_base;

  core_top dut (
    .aclk          (aclk),
    .arst_n        (arst_n),
    .push_num      (push_num),
    .push_instr0   (push_instr0),
    .push_instr1   (push_instr1),
    .free_slots    (free_slots),
    .commit_valid0 (commit_valid0),
    .commit_valid1 (commit_valid1),
    .commit_rd0    (commit_rd0),
    .commit_rd1    (commit_rd1),
    .commit_data0  (commit_data0),
    .commit_data1  (commit_data1)
  );

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge aclk);
    $display("watchdog: run did not finish within %0d cycles", WDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // rs2 sits inside the immediate bits, so only one of them is nonzero
  function automatic logic [`XLEN-1:0] enc(input core_pkg::op_e op,
                                           input logic [`REG_ADDR_W-1:0] rd,
                                           input logic [`REG_ADDR_W-1:0] rs1,
                                           input logic [`REG_ADDR_W-1:0] rs2,
                                           input logic [`IMM_W-1:0] imm);
    logic [`XLEN-1:0] w;
    w = '0;
    w[`OP_LSB +: `OPCODE_W]    = op;
    w[`RD_LSB +: `REG_ADDR_W]  = rd;
    w[`RS1_LSB +: `REG_ADDR_W] = rs1;
    w[`IMM_LSB +: `IMM_W]      = imm;
    w[`RS2_LSB +: `REG_ADDR_W] = w[`RS2_LSB +: `REG_ADDR_W] | rs2;
    return w;
  endfunction

  function automatic logic [`XLEN-1:0] build_instr(input core_pkg::op_e op,
                                                   input logic [`REG_ADDR_W-1:0] rd,
                                                   input logic [`REG_ADDR_W-1:0] ra,
                                                   input logic [`REG_ADDR_W-1:0] rb);
    if (op inside {core_pkg::OP_ADDI, core_pkg::OP_LUI}) begin
      return enc(op, rd, ra, '0, 12'($urandom));
    end
    return enc(op, rd, ra, rb, '0);
  endfunction

  // expected result from the ISA rules and the model registers
  function automatic logic [`XLEN-1:0] ref_result(input logic [`XLEN-1:0] w);
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] imm;
    a   = model_regs[w[`RS1_LSB +: `REG_ADDR_W]];
    b   = model_regs[w[`RS2_LSB +: `REG_ADDR_W]];
    imm = `XLEN'($signed(w[`IMM_LSB +: `IMM_W]));
    case (core_pkg::op_e'(w[`OP_LSB +: `OPCODE_W]))
      core_pkg::OP_ADD:  return a + b;
      core_pkg::OP_SUB:  return a - b;
      core_pkg::OP_AND:  return a & b;
      core_pkg::OP_OR:   return a | b;
      core_pkg::OP_XOR:  return a ^ b;
      core_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? `XLEN'(1) : '0;
      core_pkg::OP_ADDI: return a + imm;
      core_pkg::OP_LUI:  return {w[`IMM_LSB +: `IMM_W], {(`XLEN-`IMM_W){1'b0}}};
      default:           return '0;
    endcase
  endfunction

  task automatic model_step(input logic [`XLEN-1:0] w);
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       res;
    rd  = w[`RD_LSB +: `REG_ADDR_W];
    res = ref_result(w);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(res);
    // r0 stays zero in the model
    if (rd != '0) begin
      model_regs[rd] = res;
    end
  endtask

  task automatic check_rd(input logic [`REG_ADDR_W-1:0] exp, input logic [`REG_ADDR_W-1:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("MISMATCH %s commit_rd: expected %0d actual %0d", cur_test, exp, act);
    end
  endtask

  task automatic check_data(input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("MISMATCH %s commit_data: expected %h actual %h", cur_test, exp, act);
    end
  endtask

  task automatic check_slots(input logic [`IB_CNT_W-1:0] exp, input logic [`IB_CNT_W-1:0] act);
    check_cnt++;
    if (exp !== act) begin
      err_cnt++;
      $display("MISMATCH %s free_slots: expected %0d actual %0d", cur_test, exp, act);
    end
  endtask

  task automatic compare_commit(input logic [`REG_ADDR_W-1:0] rd, input logic [`XLEN-1:0] data);
    if (exp_rd_q.size() == 0) begin
      err_cnt++;
      $display("%s: commit seen with no instruction outstanding", cur_test);
    end else begin
      check_rd(exp_rd_q.pop_front(), rd);
      check_data(exp_data_q.pop_front(), data);
    end
  endtask

  // lane0 is the older commit of a pair
  always @(negedge aclk) begin
    if (arst_n) begin
      if (commit_valid0) begin
        compare_commit(commit_rd0, commit_data0);
      end
      if (commit_valid1) begin
        compare_commit(commit_rd1, commit_data1);
      end
    end
  end

  // greedy or random push counts bounded by free_slots
  task automatic send_program(input bit rand_counts);
    logic [1:0]       n;
    logic [`XLEN-1:0] w0;
    logic [`XLEN-1:0] w1;
    while (prog_q.size() != 0) begin
      @(negedge aclk);
      n = rand_counts ? 2'($urandom_range(2, 0)) : 2'd2;
      if (prog_q.size() < 2 && n == 2'd2) begin
        n = 2'd1;
      end
      if (free_slots < min_free) begin
        min_free = free_slots;
      end
      if (free_slots < CNT_W'(n)) begin
        n = 2'(free_slots);
      end
      w0 = '0;
      w1 = '0;
      if (n != 2'd0) begin
        w0 = prog_q.pop_front();
        model_step(w0);
      end
      if (n == 2'd2) begin
        w1 = prog_q.pop_front();
        model_step(w1);
      end
      push_num    = n;
      push_instr0 = w0;
      push_instr1 = w1;
    end
    @(negedge aclk);
    push_num = 2'd0;
  endtask

  task automatic wait_drain();
    while (exp_rd_q.size() != 0) begin
      @(negedge aclk);
    end
    repeat (4) @(negedge aclk);
    check_slots(CNT_W'(`IB_DEPTH), free_slots);
  endtask

  task automatic start_test(input string name);
    cur_test      = name;
    test_err_base = err_cnt;
  endtask

  task automatic end_test();
    test_cnt++;
    $display("%-8s %s, %0d errors", cur_test,
             (err_cnt == test_err_base) ? "ok" : "failed", err_cnt - test_err_base);
  endtask

  initial begin
    logic [`REG_ADDR_W-1:0] ra;
    logic [`REG_ADDR_W-1:0] rb;
    logic [`REG_ADDR_W-1:0] rd;
    core_pkg::op_e          op;
    void'($urandom(32'h47cd));
    arst_n      = 1'b0;
    push_num    = 2'd0;
    push_instr0 = '0;
    push_instr1 = '0;
    err_cnt     = 0;
    check_cnt   = 0;
    test_cnt    = 0;
    min_free    = CNT_W'(`IB_DEPTH);
    cur_test    = "reset";
    for (int i = 0; i < `NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    arst_n = 1'b1;

    start_test("reset");
    check_slots(CNT_W'(`IB_DEPTH), free_slots);
    repeat (10) @(negedge aclk);
    check_slots(CNT_W'(`IB_DEPTH), free_slots);
    end_test();

    // each opcode on its own three registers
    start_test("opcodes");
    for (int k = 0; k < 8; k++) begin
      ra = 5'(3 * k + 1);
      rb = 5'(3 * k + 2);
      rd = 5'(3 * k + 3);
      op = core_pkg::op_e'(4'(k));
      prog_q.push_back(enc(core_pkg::OP_LUI, ra, '0, '0, 12'($urandom)));
      prog_q.push_back(enc(core_pkg::OP_ADDI, ra, ra, '0, 12'($urandom)));
      prog_q.push_back(enc(core_pkg::OP_LUI, rb, '0, '0, 12'($urandom)));
      prog_q.push_back(enc(core_pkg::OP_ADDI, rb, rb, '0, 12'($urandom)));
      prog_q.push_back(build_instr(op, rd, ra, rb));
    end
    send_program(1'b0);
    wait_drain();
    end_test();

    start_test("pairs");
    prog_q.push_back(enc(core_pkg::OP_ADDI, 5'd10, '0, '0, 12'($urandom)));
    prog_q.push_back(enc(core_pkg::OP_ADD, 5'd11, 5'd10, 5'd10, '0));
    prog_q.push_back(enc(core_pkg::OP_LUI, 5'd12, '0, '0, 12'($urandom)));
    prog_q.push_back(enc(core_pkg::OP_SUB, 5'd13, 5'd12, 5'd10, '0));
    prog_q.push_back(enc(core_pkg::OP_ADDI, 5'd14, 5'd13, '0, 12'($urandom)));
    prog_q.push_back(enc(core_pkg::OP_SLT, 5'd15, 5'd14, 5'd13, '0));
    prog_q.push_back(enc(core_pkg::OP_XOR, 5'd16, 5'd15, 5'd14, '0));
    prog_q.push_back(enc(core_pkg::OP_OR, 5'd17, 5'd16, 5'd16, '0));
    send_program(1'b0);
    wait_drain();
    end_test();

    // second pair of each step reads both lanes of the first
    start_test("chain");
    prog_q.push_back(enc(core_pkg::OP_ADDI, 5'd2, '0, '0, 12'($urandom)));
    prog_q.push_back(enc(core_pkg::OP_ADDI, 5'd3, '0, '0, 12'($urandom)));
    for (int i = 0; i < 4; i++) begin
      prog_q.push_back(enc(core_pkg::OP_ADD, 5'd4, 5'd2, 5'd3, '0));
      prog_q.push_back(enc(core_pkg::OP_ADD, 5'd5, 5'd3, 5'd2, '0));
      prog_q.push_back(enc(core_pkg::OP_ADD, 5'd2, 5'd4, 5'd5, '0));
      prog_q.push_back(enc(core_pkg::OP_SUB, 5'd3, 5'd5, 5'd4, '0));
    end
    prog_q.push_back(enc(core_pkg::OP_ADD, 5'd6, 5'd2, 5'd3, '0));
    prog_q.push_back(enc(core_pkg::OP_XOR, 5'd6, 5'd3, 5'd2, '0));
    prog_q.push_back(enc(core_pkg::OP_ADD, 5'd7, 5'd6, 5'd6, '0));
    prog_q.push_back(enc(core_pkg::OP_ADDI, 5'd0, 5'd2, '0, 12'd77));
    prog_q.push_back(enc(core_pkg::OP_ADD, 5'd8, 5'd0, 5'd2, '0));
    send_program(1'b0);
    wait_drain();
    end_test();

    // issue always takes the head, so occupancy tops out one below depth
    start_test("fill");
    min_free = CNT_W'(`IB_DEPTH);
    for (int i = 0; i < N_FILL; i++) begin
      prog_q.push_back(enc(core_pkg::OP_ADD, 5'd5, 5'd5, 5'd6, '0));
    end
    send_program(1'b0);
    check_slots(CNT_W'(1), min_free);
    wait_drain();
    end_test();

    start_test("random");
    for (int i = 0; i < N_RAND; i++) begin
      op = core_pkg::op_e'(4'($urandom_range(7, 0)));
      rd = 5'($urandom_range(15, 0));
      ra = 5'($urandom_range(15, 0));
      rb = 5'($urandom_range(15, 0));
      prog_q.push_back(build_instr(op, rd, ra, rb));
    end
    send_program(1'b1);
    wait_drain();
    end_test();

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+source
source/core_pkg.sv
source/instr_buffer.sv
source/issue_stage.sv
source/reg_file.sv
source/exec_lane.sv
source/core_top.sv
test/core_top_checker.sv
test/core_top_tb.sv

//--- Makefile
TOP := core_top_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench, output in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  --top-module $(TOP) -Mdir $(OBJ) -f flist.f
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "no pass report in $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ) $(LOG)
